// File: logic/cache_cfg_pkg.sv
package cache_cfg_pkg;

        // direct-mapped line of four words
        localparam int LINE_WORDS = 4;

        // word select within one line
        localparam int OFFSET_W = 2;

endpackage

// File: logic/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

        typedef logic [cache_cfg_pkg::OFFSET_W-1:0] word_offset_t;

        // request levels from the cpu, held until the stall drops
        typedef struct packed {
                logic rd;
                logic wr;
        } cpu_req_t;

        // tag array result, only meaningful in a compare cycle
        typedef struct packed {
                logic valid;
                logic dirty;
                logic hit;
        } tag_status_t;

        // command to the cache array
        typedef struct packed {
                logic         enable;
                logic         comp;
                logic         write;
                word_offset_t offset;
        } cache_cmd_t;

        // command to main memory
        typedef struct packed {
                logic         wr;
                logic         rd;
                word_offset_t offset;
        } mem_cmd_t;

        typedef enum logic [2:0] {
                ST_IDLE,
                ST_ERR,
                ST_LOOKUP,
                ST_WRITEBACK,
                ST_REFILL,
                ST_RETRY
        } ctrl_state_t;

endpackage

// File: logic/access_fsm.sv
`timescale 1ns/1ps

module access_fsm (
        input  logic                       clk,
        input  logic                       rst_n,
        input  cache_ctrl_pkg::cpu_req_t    req,
        input  cache_ctrl_pkg::tag_status_t tag,
        input  logic                       wb_done,
        input  logic                       fill_done,
        input  cache_ctrl_pkg::cache_cmd_t  wb_read,
        input  cache_ctrl_pkg::cache_cmd_t  fill_cmd,
        output logic                       wb_phase,
        output logic                       refill_phase,
        output cache_ctrl_pkg::cache_cmd_t  cache_cmd,
        output logic                       cache_stall,
        output logic                       hit_check
);

        cache_ctrl_pkg::ctrl_state_t state;
        cache_ctrl_pkg::ctrl_state_t next_state;

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                        state <= cache_ctrl_pkg::ST_IDLE;
                else
                        state <= next_state;
        end

        always_comb
        begin
                next_state = state;
                case (state)
                        cache_ctrl_pkg::ST_IDLE:
                        begin
                                // both levels at once is a protocol error
                                if (req.rd && req.wr)
                                        next_state = cache_ctrl_pkg::ST_ERR;
                                else if (req.rd || req.wr)
                                        next_state = cache_ctrl_pkg::ST_LOOKUP;
                        end
                        cache_ctrl_pkg::ST_ERR:
                        begin
                                if (!(req.rd && req.wr))
                                        next_state = cache_ctrl_pkg::ST_IDLE;
                        end
                        cache_ctrl_pkg::ST_LOOKUP:
                        begin
                                if (tag.valid && tag.hit)
                                        next_state = cache_ctrl_pkg::ST_IDLE;
                                else if (tag.dirty)
                                        next_state = cache_ctrl_pkg::ST_WRITEBACK;
                                else
                                        next_state = cache_ctrl_pkg::ST_REFILL;
                        end
                        cache_ctrl_pkg::ST_WRITEBACK:
                        begin
                                if (wb_done)
                                        next_state = cache_ctrl_pkg::ST_REFILL;
                        end
                        cache_ctrl_pkg::ST_REFILL:
                        begin
                                // leave on the last fill write, reads are long finished
                                if (fill_done)
                                        next_state = cache_ctrl_pkg::ST_RETRY;
                        end
                        cache_ctrl_pkg::ST_RETRY:
                                next_state = cache_ctrl_pkg::ST_IDLE;
                        default:
                                next_state = cache_ctrl_pkg::ST_IDLE;
                endcase
        end

        assign wb_phase     = (state == cache_ctrl_pkg::ST_WRITEBACK);
        assign refill_phase = (state == cache_ctrl_pkg::ST_REFILL);

        // cpu waits in every state but idle, the error state included
        assign cache_stall = (state != cache_ctrl_pkg::ST_IDLE);

        // only the first compare can report a real hit
        assign hit_check = (state == cache_ctrl_pkg::ST_LOOKUP);

        always_comb
        begin
                cache_cmd = '0;
                case (state)
                        cache_ctrl_pkg::ST_LOOKUP,
                        cache_ctrl_pkg::ST_RETRY:
                        begin
                                cache_cmd.enable = 1'b1;
                                cache_cmd.comp   = 1'b1;
                                cache_cmd.write  = req.wr;
                        end
                        cache_ctrl_pkg::ST_WRITEBACK:
                                cache_cmd = wb_read;
                        cache_ctrl_pkg::ST_REFILL:
                                cache_cmd = fill_cmd;
                        default:
                                cache_cmd = '0;
                endcase
        end

endmodule

// File: logic/mem_sequencer.sv
`timescale 1ns/1ps

module mem_sequencer (
        input  logic                        clk,
        input  logic                        rst_n,
        input  logic                        wb_phase,
        input  logic                        refill_phase,
        input  bit                          stall,
        output cache_ctrl_pkg::mem_cmd_t     mem_cmd,
        output cache_ctrl_pkg::cache_cmd_t   wb_read,
        output logic                        wb_done,
        output logic                        push,
        output cache_ctrl_pkg::word_offset_t push_offset
);

        localparam int CNT_W = cache_cfg_pkg::OFFSET_W + 1;

        // one extra bit so the count can rest at a full line
        logic [CNT_W-1:0] cnt;
        logic             active;
        logic             accept;
        logic             last_word;

        assign active    = (cnt < CNT_W'(cache_cfg_pkg::LINE_WORDS));
        assign last_word = (cnt == CNT_W'(cache_cfg_pkg::LINE_WORDS - 1));

        assign mem_cmd.wr     = wb_phase && active;
        assign mem_cmd.rd     = refill_phase && active;
        assign mem_cmd.offset = (mem_cmd.wr || mem_cmd.rd) ?
                                cnt[cache_cfg_pkg::OFFSET_W-1:0] : '0;

        // memory takes the command in any cycle it is not busy
        assign accept = (mem_cmd.wr || mem_cmd.rd) && !stall;

        // victim word is read out of the cache alongside its memory write
        assign wb_read.enable = mem_cmd.wr;
        assign wb_read.comp   = 1'b0;
        assign wb_read.write  = 1'b0;
        assign wb_read.offset = mem_cmd.wr ? mem_cmd.offset : '0;

        assign wb_done     = mem_cmd.wr && accept && last_word;
        assign push        = mem_cmd.rd && accept;
        assign push_offset = mem_cmd.rd ? mem_cmd.offset : '0;

        always_ff @(posedge clk)
        begin
                if (!rst_n || !(wb_phase || refill_phase))
                        cnt <= '0;
                else if (accept)
                begin
                        // writeback hands straight over to refill, restart at word 0
                        if (wb_done)
                                cnt <= '0;
                        else
                                cnt <= cnt + 1'b1;
                end
        end

endmodule

// File: logic/fill_pipe.sv
`timescale 1ns/1ps

module fill_pipe #(
        parameter int MEM_LATENCY = 2
) (
        input  logic                        clk,
        input  logic                        rst_n,
        input  logic                        push,
        input  cache_ctrl_pkg::word_offset_t push_offset,
        output logic                        pop,
        output cache_ctrl_pkg::word_offset_t pop_offset
);

        // one stage per cycle of memory read latency
        logic [MEM_LATENCY-1:0]       vld;
        cache_ctrl_pkg::word_offset_t ofs [MEM_LATENCY];

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                        vld <= '0;
                else
                        vld <= (vld << 1) | MEM_LATENCY'(push);
        end

        always_ff @(posedge clk)
        begin
                ofs[0] <= push_offset;
                for (int i = 1; i < MEM_LATENCY; i++)
                        ofs[i] <= ofs[i-1];
        end

        assign pop        = vld[MEM_LATENCY-1];
        assign pop_offset = ofs[MEM_LATENCY-1];

endmodule

// File: logic/line_fill.sv
`timescale 1ns/1ps

module line_fill (
        input  logic                        clk,
        input  logic                        rst_n,
        input  logic                        pop,
        input  cache_ctrl_pkg::word_offset_t pop_offset,
        output cache_ctrl_pkg::cache_cmd_t   fill_cmd,
        output logic                        fill_done
);

        localparam int OFFSET_W = cache_cfg_pkg::OFFSET_W;

        logic [OFFSET_W-1:0] words;

        // plain write into the data array, no tag compare
        assign fill_cmd.enable = pop;
        assign fill_cmd.comp   = 1'b0;
        assign fill_cmd.write  = pop;
        assign fill_cmd.offset = pop ? pop_offset : '0;

        assign fill_done = pop && (words == OFFSET_W'(cache_cfg_pkg::LINE_WORDS - 1));

        always_ff @(posedge clk)
        begin
                if (!rst_n)
                        words <= '0;
                else if (pop)
                begin
                        // ready for the next line once this one is complete
                        if (fill_done)
                                words <= '0;
                        else
                                words <= words + 1'b1;
                end
        end

endmodule

// File: logic/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl #(
        parameter int MEM_LATENCY = 2
) (
        input  logic                       clk,
        input  logic                       rst_n,
        input  cache_ctrl_pkg::cpu_req_t    req,
        input  cache_ctrl_pkg::tag_status_t tag,
        input  bit                         stall,
        output cache_ctrl_pkg::cache_cmd_t  cache_cmd,
        output cache_ctrl_pkg::mem_cmd_t    mem_cmd,
        output bit                         cache_stall,
        output bit                         hit_check
);

        logic                         wb_phase;
        logic                         refill_phase;
        logic                         wb_done;
        logic                         fill_done;
        logic                         push;
        logic                         pop;
        cache_ctrl_pkg::word_offset_t push_offset;
        cache_ctrl_pkg::word_offset_t pop_offset;
        cache_ctrl_pkg::cache_cmd_t   wb_read;
        cache_ctrl_pkg::cache_cmd_t   fill_cmd;

        access_fsm access_fsm_inst (
                .clk          (clk),
                .rst_n        (rst_n),
                .req          (req),
                .tag          (tag),
                .wb_done      (wb_done),
                .fill_done    (fill_done),
                .wb_read      (wb_read),
                .fill_cmd     (fill_cmd),
                .wb_phase     (wb_phase),
                .refill_phase (refill_phase),
                .cache_cmd    (cache_cmd),
                .cache_stall  (cache_stall),
                .hit_check    (hit_check)
        );

        mem_sequencer mem_sequencer_inst (
                .clk          (clk),
                .rst_n        (rst_n),
                .wb_phase     (wb_phase),
                .refill_phase (refill_phase),
                .stall        (stall),
                .mem_cmd      (mem_cmd),
                .wb_read      (wb_read),
                .wb_done      (wb_done),
                .push         (push),
                .push_offset  (push_offset)
        );

        // read words come back after the memory latency
        fill_pipe #(
                .MEM_LATENCY (MEM_LATENCY)
        ) fill_pipe_inst (
                .clk         (clk),
                .rst_n       (rst_n),
                .push        (push),
                .push_offset (push_offset),
                .pop         (pop),
                .pop_offset  (pop_offset)
        );

        line_fill line_fill_inst (
                .clk        (clk),
                .rst_n      (rst_n),
                .pop        (pop),
                .pop_offset (pop_offset),
                .fill_cmd   (fill_cmd),
                .fill_done  (fill_done)
        );

endmodule

// File: test/cache_ctrl_props.sv
`timescale 1ns/1ps

module cache_ctrl_props (
        input logic                     clk,
        input logic                     rst_n,
        input cache_ctrl_pkg::mem_cmd_t mem_cmd,
        input bit                       stall,
        input bit                       hit_check
);

        // memory sees either a write or a read, never both
        a_no_wr_rd: assert property (@(posedge clk) disable iff (!rst_n)
                !(mem_cmd.wr && mem_cmd.rd))
                else $error("memory write and read active together");

        // hit_check marks the lookup state, which lasts one cycle
        a_lookup_one: assert property (@(posedge clk) disable iff (!rst_n)
                hit_check |=> !hit_check)
                else $error("lookup lasted more than one cycle");

        // a command refused by memory stays in place
        a_hold: assert property (@(posedge clk) disable iff (!rst_n)
                ((mem_cmd.wr || mem_cmd.rd) && stall) |=> $stable(mem_cmd))
                else $error("memory command changed under stall");

endmodule

bind cache_ctrl cache_ctrl_props cache_ctrl_props_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_cmd   (mem_cmd),
        .stall     (stall),
        .hit_check (hit_check)
);

// File: test/tb_cache_ctrl.sv
`timescale 1ns/1ps

module tb_cache_ctrl;

        logic                        clk;
        logic                        rst_n;
        cache_ctrl_pkg::cpu_req_t    req;
        cache_ctrl_pkg::tag_status_t tag;
        bit                          stall;
        cache_ctrl_pkg::cache_cmd_t  cache_cmd;
        cache_ctrl_pkg::mem_cmd_t    mem_cmd;
        bit                          cache_stall;
        bit                          hit_check;

        // values applied at the next falling edge
        logic                        nxt_rst_n;
        cache_ctrl_pkg::cpu_req_t    nxt_req;
        cache_ctrl_pkg::tag_status_t nxt_tag;
        bit                          stall_rand;
        int                          seed;
        int                          cycle;
        int                          errors;
        int                          tests;
        int                          failed;
        int                          acc_off[$];
        int                          acc_cyc[$];

        cache_ctrl #(
                .MEM_LATENCY (2)
        ) cache_ctrl_inst (
                .clk         (clk),
                .rst_n       (rst_n),
                .req         (req),
                .tag         (tag),
                .stall       (stall),
                .cache_cmd   (cache_cmd),
                .mem_cmd     (mem_cmd),
                .cache_stall (cache_stall),
                .hit_check   (hit_check)
        );

        initial
        begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        initial
        begin
                #200000;
                $display("watchdog expired, simulation did not finish");
                $display("TEST FAILED");
                $finish;
        end

        task automatic check_cache_cmd(input string name, input cache_ctrl_pkg::cache_cmd_t got,
                                       input cache_ctrl_pkg::cache_cmd_t exp);
                if (got !== exp)
                begin
                        $display("** Error: %s = %h, expected %h (cycle %0d)",
                                 name, got, exp, cycle);
                        errors++;
                end
        endtask

        task automatic check_mem_cmd(input string name, input cache_ctrl_pkg::mem_cmd_t got,
                                     input cache_ctrl_pkg::mem_cmd_t exp);
                if (got !== exp)
                begin
                        $display("** Error: %s = %h, expected %h (cycle %0d)",
                                 name, got, exp, cycle);
                        errors++;
                end
        endtask

        task automatic check_bit(input string name, input bit got, input bit exp);
                if (got !== exp)
                begin
                        $display("** Error: %s = %h, expected %h (cycle %0d)",
                                 name, got, exp, cycle);
                        errors++;
                end
        endtask

        // enabled cache access at one word of the line
        function automatic cache_ctrl_pkg::cache_cmd_t cache_op(input bit comp, input bit write,
                                                               input int off);
                cache_ctrl_pkg::cache_cmd_t cmd;
                cmd.enable = 1'b1;
                cmd.comp   = comp;
                cmd.write  = write;
                cmd.offset = 2'(off);
                return cmd;
        endfunction

        // memory write or read at one word of the line
        function automatic cache_ctrl_pkg::mem_cmd_t mem_op(input bit wr, input int off);
                cache_ctrl_pkg::mem_cmd_t cmd;
                cmd.wr     = wr;
                cmd.rd     = !wr;
                cmd.offset = 2'(off);
                return cmd;
        endfunction

        // drive one cycle at the falling edge and let the outputs settle
        task automatic step();
                @(negedge clk);
                rst_n = nxt_rst_n;
                req   = nxt_req;
                tag   = nxt_tag;
                stall = stall_rand ? bit'($random(seed)) : 1'b0;
                cycle++;
                #1;
        endtask

        task automatic check_idle();
                check_cache_cmd("cache_cmd", cache_cmd, '0);
                check_mem_cmd("mem_cmd", mem_cmd, '0);
                check_bit("cache_stall", cache_stall, 1'b0);
                check_bit("hit_check", hit_check, 1'b0);
        endtask

        task automatic finish_test(input string name, input int start_errors);
                tests++;
                if (errors != start_errors)
                        failed++;
                $display("test %s: %0d errors", name, errors - start_errors);
        endtask

        task automatic test_reset();
                int start;
                start = errors;
                step();
                check_idle();
                finish_test("reset", start);
        endtask

        task automatic test_hit(input bit wr);
                int start;
                start = errors;
                nxt_req = '{rd: !wr, wr: wr};
                nxt_tag = '{valid: 1'b1, dirty: 1'b0, hit: 1'b1};
                step();
                check_bit("cache_stall", cache_stall, 1'b0);
                step();
                check_cache_cmd("cache_cmd", cache_cmd, cache_op(1'b1, wr, 0));
                check_mem_cmd("mem_cmd", mem_cmd, '0);
                check_bit("hit_check", hit_check, 1'b1);
                check_bit("cache_stall", cache_stall, 1'b1);
                nxt_req = '0;
                step();
                check_idle();
                finish_test(wr ? "write_hit" : "read_hit", start);
        endtask

        task automatic test_miss(input bit dirty, input bit wr);
                int start;
                int wb_off;
                int rd_off;
                int retries;
                int n;
                int fill_off;
                int fill_cyc;
                start   = errors;
                wb_off  = 0;
                rd_off  = 0;
                retries = 0;
                nxt_req = '{rd: !wr, wr: wr};
                nxt_tag = '{valid: 1'b1, dirty: dirty, hit: 1'b0};
                step();
                stall_rand = 1'b1;
                step();
                check_bit("hit_check", hit_check, 1'b1);
                check_cache_cmd("cache_cmd", cache_cmd, cache_op(1'b1, wr, 0));
                n = 0;
                do
                begin
                        step();
                        n++;
                        if (mem_cmd.wr)
                        begin
                                check_mem_cmd("mem_cmd", mem_cmd, mem_op(1'b1, wb_off));
                                check_cache_cmd("cache_cmd", cache_cmd, cache_op(1'b0, 1'b0, wb_off));
                                if (!stall)
                                        wb_off++;
                        end
                        if (mem_cmd.rd)
                        begin
                                check_mem_cmd("mem_cmd", mem_cmd, mem_op(1'b0, rd_off));
                                if (rd_off < 4 && wb_off != (dirty ? 4 : 0))
                                begin
                                        $display("refill read issued before writeback finished");
                                        errors++;
                                end
                                if (!stall)
                                begin
                                        acc_off.push_back(rd_off);
                                        acc_cyc.push_back(cycle);
                                        rd_off++;
                                end
                        end
                        if (cache_cmd.enable && cache_cmd.write && !cache_cmd.comp)
                        begin
                                if (acc_off.size() == 0)
                                begin
                                        $display("fill write without an accepted read (cycle %0d)",
                                                 cycle);
                                        errors++;
                                end
                                else
                                begin
                                        fill_off = acc_off.pop_front();
                                        fill_cyc = acc_cyc.pop_front();
                                        check_cache_cmd("cache_cmd", cache_cmd,
                                                        cache_op(1'b0, 1'b1, fill_off));
                                        if (cycle != fill_cyc + 2)
                                        begin
                                                $display("fill write not 2 cycles after its read");
                                                errors++;
                                        end
                                end
                        end
                        if (cache_cmd.comp)
                        begin
                                // retry compare ends the miss so the cpu drops its request
                                check_cache_cmd("cache_cmd", cache_cmd, cache_op(1'b1, wr, 0));
                                check_bit("hit_check", hit_check, 1'b0);
                                retries++;
                                nxt_req = '0;
                        end
                end
                while (cache_stall && n < 200);
                stall_rand = 1'b0;
                if (cache_stall)
                begin
                        $display("timeout waiting for cache_stall to fall after a miss");
                        errors++;
                end
                if (wb_off != (dirty ? 4 : 0) || rd_off != 4 || retries != 1 ||
                    acc_off.size() != 0)
                begin
                        $display("miss sequence incomplete: %0d writes, %0d reads, %0d retries",
                                 wb_off, rd_off, retries);
                        errors++;
                end
                acc_off.delete();
                acc_cyc.delete();
                nxt_req = '0;
                step();
                check_idle();
                finish_test(dirty ? "dirty_miss" : "clean_miss", start);
        endtask

        task automatic test_conflict();
                int start;
                start   = errors;
                nxt_req = '{rd: 1'b1, wr: 1'b1};
                step();
                check_bit("cache_stall", cache_stall, 1'b0);
                repeat (5)
                begin
                        step();
                        check_bit("cache_stall", cache_stall, 1'b1);
                        check_bit("hit_check", hit_check, 1'b0);
                        check_cache_cmd("cache_cmd", cache_cmd, '0);
                        check_mem_cmd("mem_cmd", mem_cmd, '0);
                end
                nxt_req = '{rd: 1'b1, wr: 1'b0};
                step();
                check_bit("cache_stall", cache_stall, 1'b1);
                nxt_req = '0;
                repeat (2)
                begin
                        step();
                        check_idle();
                end
                finish_test("conflict", start);
        endtask

        initial
        begin
                rst_n      = 1'b0;
                req        = '0;
                tag        = '0;
                stall      = 1'b0;
                nxt_rst_n  = 1'b0;
                nxt_req    = '0;
                nxt_tag    = '0;
                stall_rand = 1'b0;
                seed       = 60654;
                cycle      = 0;
                errors     = 0;
                tests      = 0;
                failed     = 0;
                // rst_n is already low at the first rising edge
                repeat (3)
                        step();
                nxt_rst_n = 1'b1;
                test_reset();
                test_hit(1'b0);
                test_hit(1'b1);
                test_miss(1'b0, 1'b0);
                test_miss(1'b1, 1'b1);
                test_miss(1'b1, 1'b0);
                test_conflict();
                $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
                if (errors == 0)
                        $display("TEST PASSED");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

// File: sim.f
logic/cache_cfg_pkg.sv
logic/cache_ctrl_pkg.sv
logic/access_fsm.sv
logic/mem_sequencer.sv
logic/fill_pipe.sv
logic/line_fill.sv
logic/cache_ctrl.sv
test/cache_ctrl_props.sv
test/tb_cache_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_ctrl
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' sim.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) sim.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sim.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
